/* compile.f */
verilog/eth_fdx_pkg.sv
verilog/eth_fdx_regs.sv
verilog/eth_fdx_tx_sched.sv
verilog/eth_fdx_pause_gen.sv
verilog/eth_fdx_ctrl_top.sv
bench/eth_fdx_checker.sv
bench/eth_fdx_tb.sv

/* Bender.yml */
package:
  name: eth_fdx_ctrl

sources:
  - verilog/eth_fdx_pkg.sv
  - verilog/eth_fdx_regs.sv
  - verilog/eth_fdx_tx_sched.sv
  - verilog/eth_fdx_pause_gen.sv
  - verilog/eth_fdx_ctrl_top.sv
  - target: test
    files:
      - bench/eth_fdx_checker.sv
      - bench/eth_fdx_tb.sv

/* bench/eth_fdx_tb.sv */
// Flow control testbench: clock, reset, AXI4-Lite driver and seeded random tests
`timescale 1ns/1ps

module eth_fdx_tb import eth_fdx_pkg::*;;

    // AXI transfers issued by the test sequence
    localparam int op_budget = 107;

    logic clk = 1'b0;
    logic rst_n;
    logic [31:0] s_axil_awaddr, s_axil_wdata, s_axil_araddr, s_axil_rdata;
    logic [2:0]  s_axil_awprot, s_axil_arprot;
    logic [3:0]  s_axil_wstrb;
    logic [1:0]  s_axil_bresp, s_axil_rresp;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic s_axil_rvalid, s_axil_rready;
    logic tx_grant, flow_control_active, pause_tx_req;
    logic [15:0] pause_tx_quanta;

    always #10 clk = ~clk;

    eth_fdx_ctrl_top DUT (.*);
    eth_fdx_checker chk (.*);

    task automatic axil_write(input logic [3:0] word, input logic [31:0] data);
        int n;
        @(negedge clk);
        s_axil_awaddr  = {26'b0, word, 2'b00};
        s_axil_awprot  = 3'($urandom);
        s_axil_wstrb   = 4'($urandom);
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        n = 0;
        while (!s_axil_awready && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_awready) chk.flag_failure("awready never rose");
        s_axil_awvalid = 1'b0;
        n = 0;
        while (!s_axil_wready && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_wready) chk.flag_failure("wready never rose");
        s_axil_wvalid = 1'b0;
        // Back-pressure on the response channel
        repeat ($urandom % 4) @(negedge clk);
        s_axil_bready = 1'b1;
        n = 0;
        while (!s_axil_bvalid && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_bvalid) chk.flag_failure("bvalid never rose");
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] word);
        int n;
        @(negedge clk);
        s_axil_araddr  = {26'b0, word, 2'b00};
        s_axil_arprot  = 3'($urandom);
        s_axil_arvalid = 1'b1;
        n = 0;
        while (!s_axil_arready && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_arready) chk.flag_failure("arready never rose");
        s_axil_arvalid = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
        s_axil_rready = 1'b1;
        n = 0;
        while (!s_axil_rvalid && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!s_axil_rvalid) chk.flag_failure("rvalid never rose");
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic wait_grant();
        int n;
        n = 0;
        while (!tx_grant && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!tx_grant) chk.flag_failure("tx_grant never rose after the request");
    endtask

    task automatic wait_pause_end(input int limit);
        int n;
        n = 0;
        while (flow_control_active && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (flow_control_active) chk.flag_failure("flow_control_active never fell");
    endtask

    // Ends a hung run
    initial begin
        repeat (op_budget * 400) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [3:0]  regs[3];
        logic [3:0]  unmapped[5];
        logic [3:0]  a;
        int q;
        void'($urandom(32'hc1c51c55));
        regs     = '{addr_tx_request, addr_pause_quanta_rx, addr_buffer_status};
        unmapped = '{4'h5, 4'h6, 4'h7, 4'hE, 4'hF};
        rst_n = 1'b0;
        {s_axil_awaddr, s_axil_wdata, s_axil_araddr} = '0;
        {s_axil_awprot, s_axil_arprot, s_axil_wstrb} = '0;
        {s_axil_awvalid, s_axil_wvalid, s_axil_bready, s_axil_arvalid, s_axil_rready} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        chk.begin_test(0);
        repeat (24) begin
            a = regs[$urandom % 3];
            axil_write(a, $urandom);
            axil_read(a);
        end
        axil_read(addr_rx_enable);
        axil_read(addr_tx_complete);
        axil_read(addr_pause_rx);
        axil_write(addr_tx_request, 32'h0);
        axil_write(addr_tx_complete, 32'h1);
        axil_write(addr_buffer_status, 32'h0);
        repeat (20) @(negedge clk);

        chk.begin_test(1);
        for (int i = 8; i <= 13; i++) begin
            axil_write(4'(i), $urandom);
            axil_read(4'(i));
        end
        foreach (regs[i]) axil_read(regs[i]);
        foreach (unmapped[i]) begin
            axil_write(unmapped[i], $urandom);
            axil_read(unmapped[i]);
        end

        chk.begin_test(2);
        axil_write(addr_tx_request, 32'h1);
        wait_grant();
        repeat ($urandom % 8) @(negedge clk);
        axil_write(addr_tx_complete, 32'h1);
        wait_grant();
        axil_write(addr_tx_request, 32'h0);
        axil_write(addr_tx_complete, 32'h1);
        repeat (20) @(negedge clk);

        chk.begin_test(3);
        repeat (3) begin
            q = 1 + $urandom % 300;
            axil_write(addr_pause_quanta_rx, q);
            axil_write(addr_pause_rx, $urandom);
            wait_pause_end(q + 20);
        end
        // Pause arriving while a frame is granted
        axil_write(addr_tx_request, 32'h1);
        wait_grant();
        axil_write(addr_pause_quanta_rx, 50 + $urandom % 100);
        axil_write(addr_pause_rx, 32'h0);
        repeat (10) @(negedge clk);
        // Request stays high so the gap ends inside the pause
        axil_write(addr_tx_complete, 32'h1);
        wait_pause_end(200);
        wait_grant();
        axil_write(addr_tx_request, 32'h0);
        axil_write(addr_tx_complete, 32'h1);
        // XON cuts a long pause short
        axil_write(addr_pause_quanta_rx, 32'd1000);
        axil_write(addr_pause_rx, 32'h0);
        repeat (5) @(negedge clk);
        axil_write(addr_pause_quanta_rx, 32'h0);
        axil_write(addr_pause_rx, 32'h0);
        repeat (3) @(negedge clk);

        chk.begin_test(4);
        axil_write(addr_buffer_status, 32'h1);
        repeat (450) @(negedge clk);
        axil_read(addr_pause_frame_tx);
        axil_read(addr_pause_quanta_tx);
        axil_read(addr_pause_count);
        axil_write(addr_buffer_status, 32'h0);
        repeat (5) @(negedge clk);
        axil_read(addr_pause_frame_tx);
        axil_read(addr_pause_quanta_tx);
        axil_read(addr_pause_count);
        repeat (5) @(negedge clk);

        chk.report_summary();
        if (chk.total_errors() == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* bench/eth_fdx_checker.sv */
// Flow control checker: snoops the DUT ports, runs a reference model and counts mismatches
`timescale 1ns/1ps

module eth_fdx_checker import eth_fdx_pkg::*; (
    input logic                clk,
    input logic                rst_n,
    input logic [31:0]         s_axil_awaddr,
    input logic                s_axil_awready,
    input logic [31:0]         s_axil_wdata,
    input logic                s_axil_wready,
    input logic [1:0]          s_axil_bresp,
    input logic                s_axil_bvalid,
    input logic                s_axil_bready,
    input logic [31:0]         s_axil_araddr,
    input logic                s_axil_arready,
    input logic [31:0]         s_axil_rdata,
    input logic [1:0]          s_axil_rresp,
    input logic                s_axil_rvalid,
    input logic                s_axil_rready,
    input logic                tx_grant,
    input logic                flow_control_active,
    input logic                pause_tx_req,
    input logic [quanta_w-1:0] pause_tx_quanta
);

    string names[5] = '{"register_access", "responses", "grant_gap",
                        "received_pause", "pause_generation"};
    int    errs[5]  = '{0, 0, 0, 0, 0};
    int    cur_test = 0;

    // Register model
    logic                m_req;
    logic [quanta_w-1:0] m_quanta;
    logic                m_af;
    int                  pcnt;

    // Pause generator model
    logic                af_q;
    logic                exp_req;
    logic                pf;
    logic [quanta_w-1:0] lq;
    logic [count_w-1:0]  cnt;
    int                  since;

    // Grant tracking and captured bus expectations
    logic                grant_q;
    int                  cyc;
    int                  last_done;
    logic [3:0]          waddr;
    logic [3:0]          raddr;
    logic [1:0]          exp_bresp;
    logic [1:0]          exp_rresp;
    logic [31:0]         exp_rdata;
    logic                rise;
    logic                fall;
    logic                due;

    task automatic begin_test(input int idx);
        cur_test = idx;
    endtask

    task automatic value_error(input string what, input longint exp, input longint act);
        $display("ERROR [%s] %s: expected %0h, actual %0h", names[cur_test], what, exp, act);
        errs[cur_test]++;
    endtask

    task automatic flag_failure(input string msg);
        $display("Failure in %s: %s", names[cur_test], msg);
        errs[cur_test]++;
    endtask

    function automatic int total_errors();
        return errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
    endfunction

    task automatic report_summary();
        $display("Error counts: %s=%0d %s=%0d %s=%0d %s=%0d %s=%0d total=%0d",
                 names[0], errs[0], names[1], errs[1], names[2], errs[2],
                 names[3], errs[3], names[4], errs[4], total_errors());
    endtask

    // Read data the register map should return for a word address
    task automatic expect_read(input logic [3:0] a);
        exp_rresp = resp_okay;
        case (a)
            addr_tx_request:      exp_rdata = {31'b0, m_req};
            addr_pause_quanta_rx: exp_rdata = {16'b0, m_quanta};
            addr_buffer_status:   exp_rdata = {31'b0, m_af};
            addr_tx_grant:        exp_rdata = {31'b0, tx_grant};
            addr_rx_enable:       exp_rdata = 32'h1;
            addr_pause_frame_tx:  exp_rdata = {31'b0, pf};
            addr_pause_quanta_tx: exp_rdata = {16'b0, lq};
            addr_flow_ctrl_stat:  exp_rdata = {31'b0, pcnt != 0};
            addr_pause_count:     exp_rdata = {16'b0, cnt};
            addr_tx_complete, addr_pause_rx: exp_rdata = 32'h0;
            default: begin
                exp_rdata = 32'h0;
                exp_rresp = resp_slverr;
            end
        endcase
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_req     = 1'b0;
            m_quanta  = '0;
            m_af      = 1'b0;
            pcnt      = 0;
            af_q      = 1'b0;
            exp_req   = 1'b0;
            pf        = 1'b0;
            lq        = '0;
            cnt       = '0;
            since     = 0;
            grant_q   = 1'b0;
            cyc       = 0;
            last_done = -1000;
            waddr     = 4'h0;
            raddr     = 4'h0;
            exp_bresp = resp_okay;
            exp_rresp = resp_okay;
            exp_rdata = 32'h0;
        end else begin
            cyc++;
            // Outputs of the current cycle against the model
            if (flow_control_active !== (pcnt != 0))
                value_error("flow_control_active", pcnt != 0, flow_control_active);
            if (pause_tx_req !== exp_req)
                value_error("pause_tx_req", exp_req, pause_tx_req);
            else if (exp_req && pause_tx_quanta !== lq)
                value_error("pause_tx_quanta", lq, pause_tx_quanta);
            if (tx_grant && !grant_q && cyc < last_done + int'(ifg_cycles) + 2)
                flag_failure("tx_grant rose inside the inter-frame gap");
            if (tx_grant && !grant_q && pcnt != 0)
                flag_failure("tx_grant rose while a pause was in force");
            if (tx_grant && grant_q && last_done == cyc - 1)
                flag_failure("tx_grant stayed high after tx_complete");
            if (!tx_grant && grant_q && last_done != cyc - 1)
                flag_failure("tx_grant dropped without tx_complete");
            grant_q = tx_grant;

            // Bus snooping
            if (s_axil_awready) begin
                waddr     = s_axil_awaddr[5:2];
                exp_bresp = (waddr >= 4'h8 && waddr <= 4'hD) ? resp_slverr : resp_okay;
            end
            if (s_axil_arready) begin
                raddr = s_axil_araddr[5:2];
                expect_read(raddr);
            end
            if (s_axil_bvalid && s_axil_bready && s_axil_bresp !== exp_bresp)
                value_error($sformatf("bresp at word %0h", waddr), exp_bresp, s_axil_bresp);
            if (s_axil_rvalid && s_axil_rready) begin
                if (s_axil_rresp !== exp_rresp)
                    value_error($sformatf("rresp at word %0h", raddr), exp_rresp, s_axil_rresp);
                if (s_axil_rdata !== exp_rdata)
                    value_error($sformatf("rdata at word %0h", raddr), exp_rdata, s_axil_rdata);
            end

            // Strobes are live in the cycle wready is high
            if (pause_rx_strobe()) begin
                pcnt = m_quanta;
            end else if (pcnt != 0) begin
                pcnt--;
            end
            if (s_axil_wready) begin
                case (waddr)
                    addr_tx_request:      m_req    = s_axil_wdata[0];
                    addr_pause_quanta_rx: m_quanta = s_axil_wdata[15:0];
                    addr_buffer_status:   m_af     = s_axil_wdata[0];
                    addr_tx_complete: if (s_axil_wdata[0] && tx_grant) last_done = cyc;
                    default: ;
                endcase
            end

            // Pause requests for the next cycle
            rise    = m_af && !af_q;
            fall    = !m_af && af_q;
            due     = m_af && af_q && since == pause_refresh_cycles;
            exp_req = rise || fall || due;
            if (rise || due) begin
                pf    = 1'b1;
                lq    = pause_quanta_xoff;
                since = 1;
            end else begin
                if (fall) begin
                    pf = 1'b0;
                    lq = '0;
                end
                if (since < 65535)
                    since++;
            end
            if (exp_req)
                cnt++;
            af_q = m_af;
        end
    end

    function automatic logic pause_rx_strobe();
        return s_axil_wready && waddr == addr_pause_rx;
    endfunction

endmodule

/* verilog/eth_fdx_ctrl_top.sv */
// Full-duplex MAC transmit flow control top: registers, scheduler and pause generator
`timescale 1ns/1ps

module eth_fdx_ctrl_top import eth_fdx_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    input  logic [31:0]         s_axil_awaddr,
    input  logic [2:0]          s_axil_awprot,
    input  logic                s_axil_awvalid,
    output logic                s_axil_awready,
    input  logic [31:0]         s_axil_wdata,
    input  logic [3:0]          s_axil_wstrb,
    input  logic                s_axil_wvalid,
    output logic                s_axil_wready,
    output logic [1:0]          s_axil_bresp,
    output logic                s_axil_bvalid,
    input  logic                s_axil_bready,
    input  logic [31:0]         s_axil_araddr,
    input  logic [2:0]          s_axil_arprot,
    input  logic                s_axil_arvalid,
    output logic                s_axil_arready,
    output logic [31:0]         s_axil_rdata,
    output logic [1:0]          s_axil_rresp,
    output logic                s_axil_rvalid,
    input  logic                s_axil_rready,

    // To the MAC transmitter
    output logic                tx_grant,
    output logic                flow_control_active,
    output logic                pause_tx_req,
    output logic [quanta_w-1:0] pause_tx_quanta
);

    logic                tx_request;
    logic                tx_complete;
    logic                pause_rx;
    logic [quanta_w-1:0] pause_quanta_rx;
    logic                rx_almost_full;
    logic                pause_frame_tx;
    logic [count_w-1:0]  pause_count;

    eth_fdx_regs u_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .s_axil_awaddr       (s_axil_awaddr),
        .s_axil_awprot       (s_axil_awprot),
        .s_axil_awvalid      (s_axil_awvalid),
        .s_axil_awready      (s_axil_awready),
        .s_axil_wdata        (s_axil_wdata),
        .s_axil_wstrb        (s_axil_wstrb),
        .s_axil_wvalid       (s_axil_wvalid),
        .s_axil_wready       (s_axil_wready),
        .s_axil_bresp        (s_axil_bresp),
        .s_axil_bvalid       (s_axil_bvalid),
        .s_axil_bready       (s_axil_bready),
        .s_axil_araddr       (s_axil_araddr),
        .s_axil_arprot       (s_axil_arprot),
        .s_axil_arvalid      (s_axil_arvalid),
        .s_axil_arready      (s_axil_arready),
        .s_axil_rdata        (s_axil_rdata),
        .s_axil_rresp        (s_axil_rresp),
        .s_axil_rvalid       (s_axil_rvalid),
        .s_axil_rready       (s_axil_rready),
        .tx_grant            (tx_grant),
        .flow_control_active (flow_control_active),
        .pause_frame_tx      (pause_frame_tx),
        .pause_quanta_tx     (pause_tx_quanta),
        .pause_count         (pause_count),
        .tx_request          (tx_request),
        .tx_complete         (tx_complete),
        .pause_rx            (pause_rx),
        .pause_quanta_rx     (pause_quanta_rx),
        .rx_almost_full      (rx_almost_full)
    );

    eth_fdx_tx_sched u_tx_sched (
        .clk                 (clk),
        .rst_n               (rst_n),
        .tx_request          (tx_request),
        .tx_complete         (tx_complete),
        .pause_rx            (pause_rx),
        .pause_quanta_rx     (pause_quanta_rx),
        .tx_grant            (tx_grant),
        .flow_control_active (flow_control_active)
    );

    eth_fdx_pause_gen u_pause_gen (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_almost_full  (rx_almost_full),
        .pause_tx_req    (pause_tx_req),
        .pause_tx_quanta (pause_tx_quanta),
        .pause_frame_tx  (pause_frame_tx),
        .pause_count     (pause_count)
    );

endmodule

/* verilog/eth_fdx_pause_gen.sv */
// Pause generator: XOFF/XON requests from the receive-buffer watermark, with refresh
`timescale 1ns/1ps

module eth_fdx_pause_gen import eth_fdx_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx_almost_full,
    output logic                pause_tx_req,
    output logic [quanta_w-1:0] pause_tx_quanta,
    output logic                pause_frame_tx,
    output logic [count_w-1:0]  pause_count
);

    logic        full_q;
    logic [15:0] refresh_cnt;
    logic        full_rise;
    logic        full_fall;
    logic        refresh_due;
    logic        send_xoff;
    logic        send_xon;

    assign full_rise   = rx_almost_full && !full_q;
    assign full_fall   = !rx_almost_full && full_q;
    assign refresh_due = rx_almost_full && full_q && (refresh_cnt == 16'd0);

    assign send_xoff = full_rise || refresh_due;
    assign send_xon  = full_fall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else begin
            full_q <= rx_almost_full;
        end
    end

    // Counts down to the next XOFF refresh
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt <= 16'd0;
        end else if (send_xoff) begin
            refresh_cnt <= pause_refresh_cycles - 16'd1;
        end else if (rx_almost_full && refresh_cnt != 16'd0) begin
            refresh_cnt <= refresh_cnt - 16'd1;
        end
    end

    // Request pulse, quanta held until the next request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause_tx_req    <= 1'b0;
            pause_tx_quanta <= '0;
            pause_frame_tx  <= 1'b0;
            pause_count     <= '0;
        end else begin
            pause_tx_req <= send_xoff || send_xon;
            if (send_xoff) begin
                pause_tx_quanta <= pause_quanta_xoff;
                pause_frame_tx  <= 1'b1;
            end else if (send_xon) begin
                // XON is a pause frame with zero quanta
                pause_tx_quanta <= '0;
                pause_frame_tx  <= 1'b0;
            end
            if (send_xoff || send_xon) begin
                pause_count <= pause_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/eth_fdx_tx_sched.sv */
// Transmit scheduler: grants frames, enforces the inter-frame gap and received pauses
`timescale 1ns/1ps

module eth_fdx_tx_sched import eth_fdx_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tx_request,
    input  logic                tx_complete,
    input  logic                pause_rx,
    input  logic [quanta_w-1:0] pause_quanta_rx,
    output logic                tx_grant,
    output logic                flow_control_active
);

    sched_state_e        state;
    sched_state_e        state_nxt;
    logic [quanta_w-1:0] pause_cnt;
    logic [3:0]          ifg_cnt;
    logic                pause_busy;
    logic                xoff_arriving;

    assign pause_busy    = |pause_cnt;
    assign xoff_arriving = pause_rx && |pause_quanta_rx;

    assign tx_grant            = (state == st_transmit);
    assign flow_control_active = pause_busy;

    // Pause counter runs in every state, a new pause frame overrides it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause_cnt <= '0;
        end else if (pause_rx) begin
            pause_cnt <= pause_quanta_rx;
        end else if (pause_busy) begin
            pause_cnt <= pause_cnt - 1'b1;
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // An XOFF landing this cycle blocks the grant as well
                if (pause_busy || xoff_arriving) begin
                    state_nxt = st_pause;
                end else if (tx_request) begin
                    state_nxt = st_transmit;
                end
            end
            st_transmit: begin
                // Frame runs to completion regardless of pauses
                if (tx_complete) begin
                    state_nxt = st_wait_ifg;
                end
            end
            st_pause: begin
                if (!pause_busy) begin
                    state_nxt = st_idle;
                end
            end
            st_wait_ifg: begin
                if (ifg_cnt == 4'd0) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Gap counter, loaded so that the wait lasts ifg_cycles cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifg_cnt <= 4'd0;
        end else if (state == st_transmit && tx_complete) begin
            ifg_cnt <= ifg_cycles - 4'd1;
        end else if (state == st_wait_ifg && ifg_cnt != 4'd0) begin
            ifg_cnt <= ifg_cnt - 4'd1;
        end
    end

endmodule

/* verilog/eth_fdx_regs.sv */
// Flow control register block: AXI4-Lite slave, write strobes and status readback
`timescale 1ns/1ps

module eth_fdx_regs import eth_fdx_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    // AXI4-Lite write address channel
    input  logic [31:0]         s_axil_awaddr,
    input  logic [2:0]          s_axil_awprot,
    input  logic                s_axil_awvalid,
    output logic                s_axil_awready,

    // AXI4-Lite write data channel
    input  logic [31:0]         s_axil_wdata,
    input  logic [3:0]          s_axil_wstrb,
    input  logic                s_axil_wvalid,
    output logic                s_axil_wready,

    // AXI4-Lite write response channel
    output logic [1:0]          s_axil_bresp,
    output logic                s_axil_bvalid,
    input  logic                s_axil_bready,

    // AXI4-Lite read address channel
    input  logic [31:0]         s_axil_araddr,
    input  logic [2:0]          s_axil_arprot,
    input  logic                s_axil_arvalid,
    output logic                s_axil_arready,

    // AXI4-Lite read data channel
    output logic [31:0]         s_axil_rdata,
    output logic [1:0]          s_axil_rresp,
    output logic                s_axil_rvalid,
    input  logic                s_axil_rready,

    // Status from the scheduler and the pause generator
    input  logic                tx_grant,
    input  logic                flow_control_active,
    input  logic                pause_frame_tx,
    input  logic [quanta_w-1:0] pause_quanta_tx,
    input  logic [count_w-1:0]  pause_count,

    // Control to the scheduler and the pause generator
    output logic                tx_request,
    output logic                tx_complete,
    output logic                pause_rx,
    output logic [quanta_w-1:0] pause_quanta_rx,
    output logic                rx_almost_full
);

    typedef enum logic [1:0] {
        w_idle,
        w_data,
        w_resp
    } wr_state_e;

    typedef enum logic {
        r_idle,
        r_data
    } rd_state_e;

    wr_state_e  wr_state;
    rd_state_e  rd_state;
    logic [3:0] waddr;
    logic [3:0] raddr;
    logic       waddr_ro;

    // Status words at 8 to D reject writes
    assign waddr_ro = (waddr >= addr_tx_grant) && (waddr <= addr_pause_count);

    // Write channel; prot and wstrb are not used by this register map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state        <= w_idle;
            waddr           <= 4'h0;
            s_axil_awready  <= 1'b0;
            s_axil_wready   <= 1'b0;
            s_axil_bvalid   <= 1'b0;
            s_axil_bresp    <= resp_okay;
            tx_request      <= 1'b0;
            tx_complete     <= 1'b0;
            pause_rx        <= 1'b0;
            pause_quanta_rx <= '0;
            rx_almost_full  <= 1'b0;
        end else begin
            // Strobes last a single cycle
            tx_complete <= 1'b0;
            pause_rx    <= 1'b0;
            case (wr_state)
                w_idle: begin
                    if (s_axil_awvalid) begin
                        s_axil_awready <= 1'b1;
                        waddr          <= s_axil_awaddr[5:2];
                        wr_state       <= w_data;
                    end
                end
                w_data: begin
                    s_axil_awready <= 1'b0;
                    if (s_axil_wvalid) begin
                        s_axil_wready <= 1'b1;
                        s_axil_bresp  <= waddr_ro ? resp_slverr : resp_okay;
                        wr_state      <= w_resp;
                        case (waddr)
                            addr_tx_request:      tx_request      <= s_axil_wdata[0];
                            addr_tx_complete:     tx_complete     <= s_axil_wdata[0];
                            addr_pause_rx:        pause_rx        <= 1'b1;
                            addr_pause_quanta_rx: pause_quanta_rx <= s_axil_wdata[quanta_w-1:0];
                            addr_buffer_status:   rx_almost_full  <= s_axil_wdata[0];
                            default: ;
                        endcase
                    end
                end
                w_resp: begin
                    s_axil_wready <= 1'b0;
                    // First cycle raises bvalid, then wait for bready
                    if (!s_axil_bvalid) begin
                        s_axil_bvalid <= 1'b1;
                    end else if (s_axil_bready) begin
                        s_axil_bvalid <= 1'b0;
                        wr_state      <= w_idle;
                    end
                end
                default: wr_state <= w_idle;
            endcase
        end
    end

    // Read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state       <= r_idle;
            raddr          <= 4'h0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            s_axil_rdata   <= 32'h0;
            s_axil_rresp   <= resp_okay;
        end else begin
            case (rd_state)
                r_idle: begin
                    if (s_axil_arvalid) begin
                        s_axil_arready <= 1'b1;
                        raddr          <= s_axil_araddr[5:2];
                        rd_state       <= r_data;
                    end
                end
                r_data: begin
                    s_axil_arready <= 1'b0;
                    if (!s_axil_rvalid) begin
                        s_axil_rvalid <= 1'b1;
                        s_axil_rresp  <= resp_okay;
                        case (raddr)
                            addr_tx_request:      s_axil_rdata <= {31'b0, tx_request};
                            addr_tx_complete:     s_axil_rdata <= 32'h0;
                            addr_pause_rx:        s_axil_rdata <= 32'h0;
                            addr_pause_quanta_rx: s_axil_rdata <=
                                {{(32-quanta_w){1'b0}}, pause_quanta_rx};
                            addr_buffer_status:   s_axil_rdata <= {31'b0, rx_almost_full};
                            addr_tx_grant:        s_axil_rdata <= {31'b0, tx_grant};
                            // Receiver is always on in full duplex
                            addr_rx_enable:       s_axil_rdata <= 32'h1;
                            addr_pause_frame_tx:  s_axil_rdata <= {31'b0, pause_frame_tx};
                            addr_pause_quanta_tx: s_axil_rdata <=
                                {{(32-quanta_w){1'b0}}, pause_quanta_tx};
                            addr_flow_ctrl_stat:  s_axil_rdata <= {31'b0, flow_control_active};
                            addr_pause_count:     s_axil_rdata <=
                                {{(32-count_w){1'b0}}, pause_count};
                            default: begin
                                s_axil_rdata <= 32'h0;
                                s_axil_rresp <= resp_slverr;
                            end
                        endcase
                    end else if (s_axil_rready) begin
                        s_axil_rvalid <= 1'b0;
                        rd_state      <= r_idle;
                    end
                end
                default: rd_state <= r_idle;
            endcase
        end
    end

endmodule

/* verilog/eth_fdx_pkg.sv */
// Ethernet full-duplex flow control: register map, response codes, FSM states, timing
package eth_fdx_pkg;

    // Data widths
    localparam int quanta_w = 16;
    localparam int count_w  = 16;

    // Register word addresses, taken from address bits 5:2
    localparam logic [3:0] addr_tx_request      = 4'h0;
    localparam logic [3:0] addr_tx_complete     = 4'h1;
    localparam logic [3:0] addr_pause_rx        = 4'h2;
    localparam logic [3:0] addr_pause_quanta_rx = 4'h3;
    localparam logic [3:0] addr_buffer_status   = 4'h4;
    localparam logic [3:0] addr_tx_grant        = 4'h8;
    localparam logic [3:0] addr_rx_enable       = 4'h9;
    localparam logic [3:0] addr_pause_frame_tx  = 4'hA;
    localparam logic [3:0] addr_pause_quanta_tx = 4'hB;
    localparam logic [3:0] addr_flow_ctrl_stat  = 4'hC;
    localparam logic [3:0] addr_pause_count     = 4'hD;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Transmit scheduler states, one-hot
    typedef enum logic [3:0] {
        st_idle     = 4'b0001,
        st_transmit = 4'b0010,
        st_pause    = 4'b0100,
        st_wait_ifg = 4'b1000
    } sched_state_e;

    // Inter-frame gap length in cycles
    localparam logic [3:0] ifg_cycles = 4'd12;

    // Quanta carried by an XOFF request
    localparam logic [quanta_w-1:0] pause_quanta_xoff = 16'hFFFF;

    // XOFF refresh period while the receive buffer stays almost full
    localparam logic [15:0] pause_refresh_cycles = 16'd200;

endpackage
